// ==== verilog/video_pkg.sv ====
// shared widths and the rgb565 pixel word for the lcd video path
package video_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int coord_w     = 12;  // timing counters and x/y
    localparam int frame_cnt_w = 9;   // free running frame count
    localparam int mode_w      = 2;   // four pattern modes
    localparam int mem_word_w  = 32;  // pixel pair per word

    // read request to pixel on pins, in video_clk cycles
    // one for the ram, one for the word capture
    localparam int sync_delay  = 2;

    // --------------------------------------------------
    // pixel word
    // --------------------------------------------------
    // raw view for packing into memory words,
    // field view for colour conversion and pin split
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [4:0] r;  // top 5 bits of red
            logic [5:0] g;  // top 6 bits of green
            logic [4:0] b;  // top 5 bits of blue
        } f;
    } pixel_u;

endpackage

// ==== verilog/video_timing.sv ====
// raster timing generator with syncs, data enable, active coordinates and frame count
`timescale 1ns/10ps

module video_timing #(
    parameter int h_total  = 523,
    parameter int h_sync   = 41,
    parameter int h_bporch = 2,
    parameter int h_res    = 480,
    parameter int v_total  = 284,
    parameter int v_sync   = 10,
    parameter int v_bporch = 2,
    parameter int v_res    = 272
) (
    input  logic                              video_clk,
    input  logic                              rst_n,
    output logic                              hs,
    output logic                              vs,
    output logic                              de,
    output logic [video_pkg::coord_w-1:0]     x,
    output logic [video_pkg::coord_w-1:0]     y,
    output logic [video_pkg::frame_cnt_w-1:0] frame_cnt
);

    // first active count on a line / in a frame
    localparam int h_start = h_sync + h_bporch;
    localparam int v_start = v_sync + v_bporch;

    logic [video_pkg::coord_w-1:0] h_cnt;
    logic [video_pkg::coord_w-1:0] v_cnt;
    logic                          h_last;
    logic                          v_last;
    logic                          h_act;
    logic                          v_act;

    assign h_last = (h_cnt == h_total - 1);
    assign v_last = (v_cnt == v_total - 1);

    // sync, then back porch, then active
    assign h_act = (h_cnt >= h_start) && (h_cnt < h_start + h_res);
    assign v_act = (v_cnt >= v_start) && (v_cnt < v_start + v_res);

    // --------------------------------------------------
    // counters
    // --------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            frame_cnt <= '0;  // frame 0 right after reset
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
                v_cnt     <= '0;
                frame_cnt <= frame_cnt + 1'b1;  // bump on vertical wrap
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // registered decode
    // --------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            hs <= 1'b0;
            vs <= 1'b0;
            de <= 1'b0;
            x  <= '0;
            y  <= '0;
        end else begin
            hs <= (h_cnt < h_sync);  // active high
            vs <= (v_cnt < v_sync);  // counted in lines
            de <= h_act && v_act;
            x  <= h_cnt - h_start[video_pkg::coord_w-1:0];  // only meaningful with de
            y  <= v_cnt - v_start[video_pkg::coord_w-1:0];
        end
    end

endmodule

// ==== verilog/test_pattern.sv ====
// test pattern generator, four 888 colour modes picked by the frame count
`timescale 1ns/10ps

module test_pattern #(
    parameter int          h_res      = 480,
    parameter int          mode_shift = 7,
    parameter logic [23:0] single_rgb = 24'hffffff
) (
    input  logic                              video_clk,
    input  logic                              rst_n,
    input  logic                              de_in,
    input  logic                              vs_in,
    input  logic [video_pkg::coord_w-1:0]     x,
    input  logic [video_pkg::coord_w-1:0]     y,
    input  logic [video_pkg::frame_cnt_w-1:0] frame_cnt,
    output logic                              de_out,
    output logic                              vs_out,
    output logic [23:0]                       rgb
);

    logic [video_pkg::mode_w-1:0]  mode;
    logic [video_pkg::coord_w+2:0] x8;       // x times 8
    logic [2:0]                    bar;      // bar index 0..7
    logic [2:0]                    bar_inv;  // 7 - bar, white bar first
    logic [7:0]                    gray;
    logic [23:0]                   colour;

    // mode steps every 2^mode_shift frames
    assign mode = frame_cnt[mode_shift +: video_pkg::mode_w];

    assign x8      = {x, 3'b000};
    assign bar     = 3'(x8 / h_res);
    assign bar_inv = 3'd7 - bar;
    assign gray    = {x[5:0], 2'b00};  // low 8 bits of x*4

    // --------------------------------------------------
    // colour select
    // --------------------------------------------------
    always_comb begin
        case (mode)
            2'd0: begin
                // colour bars, one bit per channel
                colour = {{8{bar_inv[2]}}, {8{bar_inv[1]}}, {8{bar_inv[0]}}};
            end
            2'd1: begin
                // 8x8 checker
                colour = (x[3] ^ y[3]) ? 24'hffffff : 24'h000000;
            end
            2'd2: colour = {gray, gray, gray};  // horizontal ramp
            default: colour = single_rgb;
        endcase
    end

    // output register stage
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            de_out <= 1'b0;
            vs_out <= 1'b0;
        end else begin
            de_out <= de_in;  // one cycle behind timing
            vs_out <= vs_in;
        end
    end

    always_ff @(posedge video_clk) begin
        rgb <= colour;
    end

endmodule

// ==== verilog/frame_writer.sv ====
// frame writer, 888 to 565 conversion and pixel pair packing into memory words
`timescale 1ns/10ps

module frame_writer #(
    parameter int addr_w = 16
) (
    input  logic                             video_clk,
    input  logic                             rst_n,
    input  logic                             de,
    input  logic                             vs,
    input  logic [23:0]                      rgb,
    input  logic                             wr_gnt,
    output logic                             wr_req,
    output logic [addr_w-1:0]                wr_addr,
    output logic [video_pkg::mem_word_w-1:0] wr_data
);

    logic                vs_q;
    logic                vs_rise;
    logic [addr_w:0]     pix_cnt;   // active pixel index in frame
    logic                pair_done; // odd pixel present
    video_pkg::pixel_u   cur_px;
    video_pkg::pixel_u   even_px;   // held until its partner arrives

    assign vs_rise   = vs & ~vs_q;
    assign pair_done = de & pix_cnt[0];

    // truncate each channel to its top bits
    always_comb begin
        cur_px.f.r = rgb[23:19];
        cur_px.f.g = rgb[15:10];
        cur_px.f.b = rgb[7:3];
    end

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            vs_q    <= 1'b0;
            pix_cnt <= '0;
            wr_req  <= 1'b0;
        end else begin
            vs_q <= vs;
            if (vs_rise) begin
                pix_cnt <= '0;  // new frame
            end else if (de) begin
                pix_cnt <= pix_cnt + 1'b1;
            end

            // new pair posts a request, grant clears it
            if (pair_done) begin
                wr_req <= 1'b1;
            end else if (wr_gnt) begin
                wr_req <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // payload
    // --------------------------------------------------
    always_ff @(posedge video_clk) begin
        if (de && !pix_cnt[0]) begin
            even_px <= cur_px;
        end
        if (pair_done) begin
            wr_data <= {cur_px.raw, even_px.raw};  // even pixel low half
            wr_addr <= pix_cnt[addr_w:1];          // pair index
        end
    end

endmodule

// ==== verilog/frame_scanout.sv ====
// frame scanout, reads pixel pairs back and drives the rgb565 lcd pins with delayed syncs
`timescale 1ns/10ps

module frame_scanout #(
    parameter int addr_w = 16
) (
    input  logic                             video_clk,
    input  logic                             rst_n,
    input  logic                             hs,
    input  logic                             vs,
    input  logic                             de,
    input  logic [video_pkg::mem_word_w-1:0] rd_data,
    output logic                             rd_req,
    output logic [addr_w-1:0]                rd_addr,
    output logic                             lcd_hs,
    output logic                             lcd_vs,
    output logic                             lcd_de,
    output logic [4:0]                       lcd_r,
    output logic [5:0]                       lcd_g,
    output logic [4:0]                       lcd_b
);

    localparam int dly = video_pkg::sync_delay;

    logic                             vs_q;
    logic [addr_w:0]                  pix_cnt;  // active pixel index in frame
    logic                             rd_valid; // ram data valid this cycle
    logic [video_pkg::mem_word_w-1:0] word_q;   // captured pixel pair
    logic [dly-1:0]                   hs_sr;
    logic [dly-1:0]                   vs_sr;
    logic [dly-1:0]                   de_sr;
    logic [dly-1:0]                   half_sr;  // odd pixel flag, delayed
    video_pkg::pixel_u                px;

    // one read per pair, on the even pixel
    assign rd_req  = de & ~pix_cnt[0];
    assign rd_addr = pix_cnt[addr_w:1];

    // --------------------------------------------------
    // pixel count and delay lines
    // --------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            vs_q     <= 1'b0;
            pix_cnt  <= '0;
            rd_valid <= 1'b0;
            hs_sr    <= '0;
            vs_sr    <= '0;
            de_sr    <= '0;
            half_sr  <= '0;
        end else begin
            vs_q <= vs;
            if (vs && !vs_q) begin
                pix_cnt <= '0;  // restart on vs rising
            end else if (de) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
            rd_valid <= rd_req;  // ram latency is one cycle
            hs_sr    <= {hs_sr[dly-2:0], hs};
            vs_sr    <= {vs_sr[dly-2:0], vs};
            de_sr    <= {de_sr[dly-2:0], de};
            half_sr  <= {half_sr[dly-2:0], pix_cnt[0]};
        end
    end

    // word holds for the even and the odd pixel
    always_ff @(posedge video_clk) begin
        if (rd_valid) begin
            word_q <= rd_data;
        end
    end

    // --------------------------------------------------
    // pin drive
    // --------------------------------------------------
    assign lcd_hs = hs_sr[dly-1];
    assign lcd_vs = vs_sr[dly-1];
    assign lcd_de = de_sr[dly-1];

    assign px.raw = half_sr[dly-1] ? word_q[31:16] : word_q[15:0];

    assign lcd_r = lcd_de ? px.f.r : 5'd0;  // blank outside active
    assign lcd_g = lcd_de ? px.f.g : 6'd0;
    assign lcd_b = lcd_de ? px.f.b : 5'd0;

endmodule

// ==== verilog/mem_arbiter.sv ====
// fixed priority arbiter for the frame memory port, scanout reader ahead of writer
`timescale 1ns/10ps

module mem_arbiter #(
    parameter int addr_w = 16
) (
    input  logic                             rd_req,
    input  logic [addr_w-1:0]                rd_addr,
    input  logic                             wr_req,
    input  logic [addr_w-1:0]                wr_addr,
    input  logic [video_pkg::mem_word_w-1:0] wr_data,
    output logic                             wr_gnt,
    output logic                             mem_we,
    output logic [addr_w-1:0]                mem_addr,
    output logic [video_pkg::mem_word_w-1:0] mem_wdata
);

    // reader never waits, it has no slack against the raster
    assign wr_gnt = wr_req & ~rd_req;

    // write strobe only on a granted cycle
    assign mem_we = wr_gnt;

    // address follows the winner
    assign mem_addr = rd_req ? rd_addr : wr_addr;

    // write data only matters with mem_we
    assign mem_wdata = wr_data;

endmodule

// ==== verilog/frame_ram.sv ====
// single port frame memory with registered read data
`timescale 1ns/10ps

module frame_ram #(
    parameter int addr_w = 16
) (
    input  logic                             video_clk,
    input  logic                             we,
    input  logic [addr_w-1:0]                addr,
    input  logic [video_pkg::mem_word_w-1:0] wdata,
    output logic [video_pkg::mem_word_w-1:0] rdata
);

    // one word per pixel pair
    logic [video_pkg::mem_word_w-1:0] mem [2**addr_w];

    always_ff @(posedge video_clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // valid the cycle after the request
    end

endmodule

// ==== verilog/lcd_frame_top.sv ====
// lcd frame path top, timing and test pattern through the frame memory to the lcd pins
`timescale 1ns/10ps

module lcd_frame_top #(
    parameter int          h_total    = 523,
    parameter int          h_sync     = 41,
    parameter int          h_bporch   = 2,
    parameter int          h_res      = 480,
    parameter int          v_total    = 284,
    parameter int          v_sync     = 10,
    parameter int          v_bporch   = 2,
    parameter int          v_res      = 272,
    parameter int          mode_shift = 7,
    parameter int          addr_w     = 16,
    parameter logic [23:0] single_rgb = 24'hffffff
) (
    input  logic       video_clk,
    input  logic       rst_n,
    output logic       lcd_hs,
    output logic       lcd_vs,
    output logic       lcd_de,
    output logic [4:0] lcd_r,
    output logic [5:0] lcd_g,
    output logic [4:0] lcd_b
);

    // --------------------------------------------------
    // internal raster
    // --------------------------------------------------
    logic                              hs;
    logic                              vs;
    logic                              de;
    logic [video_pkg::coord_w-1:0]     x;
    logic [video_pkg::coord_w-1:0]     y;
    logic [video_pkg::frame_cnt_w-1:0] frame_cnt;

    // pattern stage, one cycle late
    logic        tp_de;
    logic        tp_vs;
    logic [23:0] tp_rgb;

    // memory side
    logic                             wr_req;
    logic                             wr_gnt;
    logic [addr_w-1:0]                wr_addr;
    logic [video_pkg::mem_word_w-1:0] wr_data;
    logic                             rd_req;
    logic [addr_w-1:0]                rd_addr;
    logic [video_pkg::mem_word_w-1:0] rd_data;
    logic                             mem_we;
    logic [addr_w-1:0]                mem_addr;
    logic [video_pkg::mem_word_w-1:0] mem_wdata;

    video_timing #(
        .h_total  (h_total),
        .h_sync   (h_sync),
        .h_bporch (h_bporch),
        .h_res    (h_res),
        .v_total  (v_total),
        .v_sync   (v_sync),
        .v_bporch (v_bporch),
        .v_res    (v_res)
    ) i_video_timing (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .hs        (hs),
        .vs        (vs),
        .de        (de),
        .x         (x),
        .y         (y),
        .frame_cnt (frame_cnt)
    );

    test_pattern #(
        .h_res      (h_res),
        .mode_shift (mode_shift),
        .single_rgb (single_rgb)
    ) i_test_pattern (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .de_in     (de),
        .vs_in     (vs),
        .x         (x),
        .y         (y),
        .frame_cnt (frame_cnt),
        .de_out    (tp_de),
        .vs_out    (tp_vs),
        .rgb       (tp_rgb)
    );

    // writer side of the shared port
    frame_writer #(
        .addr_w (addr_w)
    ) i_frame_writer (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .de        (tp_de),
        .vs        (tp_vs),
        .rgb       (tp_rgb),
        .wr_gnt    (wr_gnt),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    // reader side, straight off the timing
    frame_scanout #(
        .addr_w (addr_w)
    ) i_frame_scanout (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .hs        (hs),
        .vs        (vs),
        .de        (de),
        .rd_data   (rd_data),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .lcd_hs    (lcd_hs),
        .lcd_vs    (lcd_vs),
        .lcd_de    (lcd_de),
        .lcd_r     (lcd_r),
        .lcd_g     (lcd_g),
        .lcd_b     (lcd_b)
    );

    mem_arbiter #(
        .addr_w (addr_w)
    ) i_mem_arbiter (
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_gnt    (wr_gnt),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    frame_ram #(
        .addr_w (addr_w)
    ) i_frame_ram (
        .video_clk (video_clk),
        .we        (mem_we),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .rdata     (rd_data)
    );

endmodule

// ==== tests/tb_checker.sv ====
// lcd pin checker, reset state, raster shape and pixel compare against the reference model
`timescale 1ns/10ps

module tb_checker #(
    parameter int h_total    = 24,
    parameter int h_sync     = 2,
    parameter int h_bporch   = 2,
    parameter int h_res      = 16,
    parameter int v_total    = 11,
    parameter int v_res      = 8,
    parameter int last_frame = 8
) (
    input  logic        video_clk,
    input  logic        rst_n,
    input  logic        lcd_hs,
    input  logic        lcd_vs,
    input  logic        lcd_de,
    input  logic [4:0]  lcd_r,
    input  logic [5:0]  lcd_g,
    input  logic [4:0]  lcd_b,
    input  logic [15:0] exp_px,     // reference for ref_frame, ref_x, ref_y
    output int          ref_frame,
    output int          ref_x,
    output int          ref_y,
    output logic        done,
    output int          tests_run,
    output int          tests_failed
);

    int                frame_idx;   // lcd_vs rises minus 1
    int                px_x;
    int                px_y;
    int                px_cnt;
    int                px_errs;
    int                raster_errs;
    int                reset_errs;
    int                hs_len;
    int                hs_period;
    int                de_len;
    int                lines;
    int                act_lines;
    logic              hs_q;
    logic              vs_q;
    logic              de_q;
    logic              hs_seen;
    logic              reset_done;
    video_pkg::pixel_u act;

    // output frame n shows input frame n-1
    assign ref_frame = frame_idx - 1;
    assign ref_x     = px_x;
    assign ref_y     = px_y;

    initial begin
        frame_idx    = -1;
        {px_x, px_y, px_cnt, px_errs} = '0;
        {raster_errs, reset_errs, hs_len, hs_period} = '0;
        {de_len, lines, act_lines} = '0;
        {hs_q, vs_q, de_q, hs_seen, reset_done} = '0;
        done         = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
    end

    // two output frames per pattern mode
    function automatic string frame_test(input int n);
        string base;
        case ((n - 1) >> 1)
            0: base = "colour_bars";
            1: base = "checker";
            2: base = "gray_ramp";
            default: base = "single_colour";
        endcase
        return $sformatf("%s_f%0d", base, n);
    endfunction

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %-18s ok", name);
        end else begin
            tests_failed++;
            $display("test %-18s %0d errors", name, errs);
        end
    endtask

    task automatic raster_value(input string what, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            raster_errs++;
            $display("FAIL raster_shape %s expected %0d actual %0d", what, exp_v, act_v);
        end
    endtask

    // --------------------------------------------------
    // sample on the falling edge where pins are settled
    // --------------------------------------------------
    always @(negedge video_clk) begin
        if (rst_n !== 1'b1) begin
            if (lcd_hs || lcd_vs || lcd_de) begin
                reset_errs++;
                $display("reset_state: lcd sync or enable pin high while rst_n is low");
            end
        end else if (!done) begin
            if (!reset_done) begin
                report_test("reset_state", reset_errs);
                reset_done = 1'b1;
            end

            // close the frame just shown at a frame boundary
            if (lcd_vs && !vs_q) begin
                raster_value("vs on hs rise", 1, int'(lcd_hs && !hs_q));
                if (frame_idx >= 0) begin
                    raster_value("lines per frame", v_total, lines);
                    raster_value("active lines", v_res, act_lines);
                end
                if (frame_idx >= 1 && frame_idx <= last_frame) begin
                    if (px_cnt != h_res * v_res) begin
                        px_errs++;
                        $display("FAIL %s pixel count expected %0d actual %0d",
                                 frame_test(frame_idx), h_res * v_res, px_cnt);
                    end
                    report_test(frame_test(frame_idx), px_errs);
                end
                frame_idx++;
                {lines, act_lines, px_x, px_y, px_cnt, px_errs} = '0;
                if (frame_idx > last_frame) begin
                    report_test("raster_shape", raster_errs);
                    $display("tests run %0d, failed %0d", tests_run, tests_failed);
                    done = 1'b1;
                end
            end

            // horizontal sync width and period
            if (lcd_hs && !hs_q) begin
                lines++;
                if (hs_seen) raster_value("hs period", h_total, hs_period);
                hs_seen   = 1'b1;
                hs_period = 1;
            end else begin
                hs_period++;
            end
            if (lcd_hs) hs_len++;
            if (!lcd_hs && hs_q) begin
                raster_value("hs width", h_sync, hs_len);
                hs_len = 0;
            end

            // first active pixel sits after sync and back porch
            if (lcd_de && !de_q) begin
                raster_value("hs to de", h_sync + h_bporch, hs_period - 1);
            end

            // active pixels with exp_px tracking px_x and px_y
            if (lcd_de) begin
                if (frame_idx >= 1 && frame_idx <= last_frame) begin
                    act.f.r = lcd_r;
                    act.f.g = lcd_g;
                    act.f.b = lcd_b;
                    if (act.raw !== exp_px) begin
                        px_errs++;
                        $display("FAIL %s x=%0d y=%0d expected %04h actual %04h",
                                 frame_test(frame_idx), px_x, px_y, exp_px, act.raw);
                    end
                end
                px_x++;
                px_cnt++;
                de_len++;
            end
            if (!lcd_de && de_q) begin  // end of an active line
                raster_value("de width", h_res, de_len);
                de_len = 0;
                act_lines++;
                px_x = 0;
                px_y++;
            end
        end
        hs_q = lcd_hs;
        vs_q = lcd_vs;
        de_q = lcd_de;
    end

endmodule

// ==== tests/tb_lcd_frame.sv ====
// testbench top for the lcd frame path, clock, reset, reference pixel model and run limit
`timescale 1ns/10ps

module tb_lcd_frame;

    // small raster of 24 x 11 = 264 cycles per frame
    localparam int          h_total    = 24;
    localparam int          h_res      = 16;
    localparam int          v_total    = 11;
    localparam int          v_res      = 8;
    localparam int          mode_shift = 1;   // mode steps every two frames
    localparam logic [23:0] single_rgb = 24'h3c9a57;  // low bits drop on truncation
    localparam int          last_frame = 8;
    localparam int          n_tests    = last_frame + 2;  // plus reset and raster

    // reset plus ten output frames fit well inside twelve
    localparam int frame_cycles = h_total * v_total;
    localparam int max_cycles   = 12 * frame_cycles;

    logic        video_clk;
    logic        rst_n;
    logic        lcd_hs;
    logic        lcd_vs;
    logic        lcd_de;
    logic [4:0]  lcd_r;
    logic [5:0]  lcd_g;
    logic [4:0]  lcd_b;
    logic [15:0] exp_px;
    logic        chk_done;
    int          ref_frame;
    int          ref_x;
    int          ref_y;
    int          tests_run;
    int          tests_failed;
    int          cycle_cnt;

    // --------------------------------------------------
    // reference 565 pixel from the 888 pattern rules
    // --------------------------------------------------
    function automatic logic [15:0] ref_pixel(input int frame, input int px, input int py);
        int         mode;
        int         bar;
        logic [2:0] bar_inv;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [7:0] gray;
        mode = (frame >> mode_shift) & 3;
        case (mode)
            0: begin
                bar     = px * 8 / h_res;  // eight bars across
                bar_inv = 3'(7 - bar);     // white bar on the left
                r       = bar_inv[2] ? 8'hff : 8'h00;
                g       = bar_inv[1] ? 8'hff : 8'h00;
                b       = bar_inv[0] ? 8'hff : 8'h00;
            end
            1: begin
                r = (px[3] ^ py[3]) ? 8'hff : 8'h00;  // 8x8 squares
                g = r;
                b = r;
            end
            2: begin
                gray = 8'(px * 4);
                r    = gray;
                g    = gray;
                b    = gray;
            end
            default: {r, g, b} = single_rgb;
        endcase
        return {r[7:3], g[7:2], b[7:3]};  // keep top bits only
    endfunction

    assign exp_px = ref_pixel(ref_frame, ref_x, ref_y);

    // --------------------------------------------------
    // clock and reset
    // --------------------------------------------------
    initial begin
        video_clk = 1'b0;
        forever #2 video_clk = ~video_clk;  // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge video_clk);
        @(negedge video_clk);
        rst_n = 1'b1;  // released on a falling edge
    end

    lcd_frame_top #(
        .h_total    (h_total),
        .h_sync     (2),
        .h_bporch   (2),
        .h_res      (h_res),
        .v_total    (v_total),
        .v_sync     (1),
        .v_bporch   (1),
        .v_res      (v_res),
        .mode_shift (mode_shift),
        .addr_w     (6),
        .single_rgb (single_rgb)
    ) i_lcd_frame_top (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .lcd_hs    (lcd_hs),
        .lcd_vs    (lcd_vs),
        .lcd_de    (lcd_de),
        .lcd_r     (lcd_r),
        .lcd_g     (lcd_g),
        .lcd_b     (lcd_b)
    );

    tb_checker #(
        .h_total    (h_total),
        .h_sync     (2),
        .h_bporch   (2),
        .h_res      (h_res),
        .v_total    (v_total),
        .v_res      (v_res),
        .last_frame (last_frame)
    ) i_tb_checker (
        .video_clk    (video_clk),
        .rst_n        (rst_n),
        .lcd_hs       (lcd_hs),
        .lcd_vs       (lcd_vs),
        .lcd_de       (lcd_de),
        .lcd_r        (lcd_r),
        .lcd_g        (lcd_g),
        .lcd_b        (lcd_b),
        .exp_px       (exp_px),
        .ref_frame    (ref_frame),
        .ref_x        (ref_x),
        .ref_y        (ref_y),
        .done         (chk_done),
        .tests_run    (tests_run),
        .tests_failed (tests_failed)
    );

    // --------------------------------------------------
    // run control
    // --------------------------------------------------
    initial begin
        cycle_cnt = 0;
        while (chk_done !== 1'b1 && cycle_cnt < max_cycles) begin
            @(posedge video_clk);
            cycle_cnt++;
        end
        if (chk_done !== 1'b1) begin
            $display("timeout: checker did not reach frame %0d within %0d cycles",
                     last_frame, max_cycles);
            $display("Result: FAILED");
        end else if (tests_failed == 0 && tests_run == n_tests) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/test_pattern.sv
verilog/frame_writer.sv
verilog/frame_scanout.sv
verilog/mem_arbiter.sv
verilog/frame_ram.sv
verilog/lcd_frame_top.sv
tests/tb_checker.sv
tests/tb_lcd_frame.sv
